/* verilog/restart_defines.svh */
//////////////////////////////
// Sizing for the restart path
// Tag width must cover the tag count
// Credit width must hold the credit total plus one
//////////////////////////////

`ifndef RESTART_DEFINES_SVH
`define RESTART_DEFINES_SVH

// Tag table
`define RST_TAG_COUNT 16
`define RST_TAG_W 4

// Link credits
`define RST_CREDITS 8
`define RST_CREDIT_W 4

// Command fields
`define RST_ADDR_W 32
`define RST_CU_W 4
`define RST_RESTART_CU {`RST_CU_W{1'b1}}

`endif

/* verilog/restart_pkg.sv */
//////////////////////////////
// Types shared by the restart path
// Widths come from the defines header
//////////////////////////////

`include "restart_defines.svh"

package restart_pkg;

	typedef logic [`RST_TAG_W-1:0] tag_t;
	typedef logic [`RST_ADDR_W-1:0] addr_t;
	typedef logic [`RST_CU_W-1:0] cu_t;
	typedef logic [`RST_CREDIT_W-1:0] credit_t;

	// Command kinds
	typedef logic [1:0] cmd_kind_t;
	localparam cmd_kind_t KIND_READ = 2'd0;
	localparam cmd_kind_t KIND_WRITE = 2'd1;
	localparam cmd_kind_t KIND_RESTART = 2'd2;

	// Response codes
	typedef logic [2:0] rsp_code_t;
	localparam rsp_code_t RSP_DONE = 3'd0;
	localparam rsp_code_t RSP_PAGED = 3'd1;
	localparam rsp_code_t RSP_AERROR = 3'd2;
	localparam rsp_code_t RSP_DERROR = 3'd3;
	localparam rsp_code_t RSP_FLUSHED = 3'd4;

	// One enable bit per restartable fault
	typedef logic [2:0] restart_mask_t;
	localparam int MASK_PAGED = 0;
	localparam int MASK_AERROR = 1;
	localparam int MASK_DERROR = 2;

	typedef struct packed {
		addr_t addr;
		cu_t cu;
		cmd_kind_t kind;
	} cmd_entry_t;

	// Flushed command as kept for replay
	typedef struct packed {
		tag_t tag;
		cmd_entry_t entry;
	} replay_entry_t;

	typedef enum logic [2:0] {IDLE, RESTART, RESP_WAIT, REPLAY, DONE} restart_state_e;

endpackage

/* verilog/cmd_line_if.sv */
//////////////////////////////
// One outbound command line
// No handshake, valid is a strobe
//////////////////////////////

`timescale 1ns/1ns

interface cmd_line_if;
	import restart_pkg::*;

	logic valid;
	tag_t tag;
	addr_t addr;
	cu_t cu;
	cmd_kind_t kind;
	// Set on restart and replay commands
	logic strict;

	modport source (
		output valid, tag, addr, cu, kind, strict
	);

	modport sink (
		input valid, tag, addr, cu, kind, strict
	);

endinterface

/* verilog/tag_ram.sv */
//////////////////////////////
// Outstanding command table
// Read data one cycle after address, no reset
//////////////////////////////

`timescale 1ns/1ns
`include "restart_defines.svh"

module tag_ram #(
	parameter int DEPTH = `RST_TAG_COUNT,
	parameter int WIDTH = $bits(restart_pkg::cmd_entry_t)
) (
	input  logic                    clock,
	input  logic                    we,
	input  restart_pkg::tag_t       wr_addr,
	input  restart_pkg::cmd_entry_t wr_data,
	input  restart_pkg::tag_t       rd_addr,
	output restart_pkg::cmd_entry_t rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* verilog/replay_fifo.sv */
//////////////////////////////
// Replay buffer for flushed commands
// DEPTH must be a power of two
// Push while full is dropped
//////////////////////////////

`timescale 1ns/1ns
`include "restart_defines.svh"

module replay_fifo #(
	parameter int DEPTH = `RST_TAG_COUNT,
	parameter int WIDTH = $bits(restart_pkg::replay_entry_t)
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  restart_pkg::replay_entry_t push_data,
	input  logic                       pop,
	output restart_pkg::replay_entry_t pop_data,
	output logic                       empty,
	output logic                       full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	always_ff @(posedge clock) begin
		if (push && !full) begin
			mem[wr_ptr[AW-1:0]] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Head entry visible before the pop
	assign pop_data = mem[rd_ptr[AW-1:0]];

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

/* verilog/credit_tracker.sv */
//////////////////////////////
// Link credits in use
// One credit per outbound command
// One back per response
//////////////////////////////

`timescale 1ns/1ns

module credit_tracker (
	input  logic                 clock,
	input  logic                 rstn,
	cmd_line_if.sink             cmd,
	input  logic                 rsp_valid,
	output restart_pkg::credit_t credits_used
);

	logic take;
	logic give;

	assign take = cmd.valid;
	// Stray response at zero is ignored
	assign give = rsp_valid && (credits_used != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			credits_used <= '0;
		end else begin
			case ({take, give})
				2'b10: credits_used <= credits_used + 1'b1;
				2'b01: credits_used <= credits_used - 1'b1;
				// Send and return in one cycle cancel
				default: credits_used <= credits_used;
			endcase
		end
	end

endmodule

/* verilog/restart_config.sv */
//////////////////////////////
// Configuration registers
// Address 0 bit 0 is the enable
// Address 1 bits 2..0 are the fault mask
//////////////////////////////

`timescale 1ns/1ns

module restart_config (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       cfg_we,
	input  logic                       cfg_addr,
	input  logic [7:0]                 cfg_wdata,
	output logic                       enable,
	output restart_pkg::restart_mask_t restart_mask
);

	// Comes up disabled with no fault restartable
	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enable <= 1'b0;
			restart_mask <= '0;
		end else begin
			if (cfg_we) begin
				case (cfg_addr)
					1'b0: enable <= cfg_wdata[0];
					1'b1: restart_mask <= cfg_wdata[2:0];
					default: enable <= enable;
				endcase
			end
		end
	end

endmodule

/* verilog/restart_control.sv */
//////////////////////////////
// Restart sequencing for the command port
// Response entry is read two cycles after rsp_valid
// Replay buffer is not cleared by a disable
//////////////////////////////

`timescale 1ns/1ns
`include "restart_defines.svh"

module restart_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  restart_pkg::restart_mask_t restart_mask,
	input  logic                       host_valid,
	input  restart_pkg::tag_t          host_tag,
	input  restart_pkg::addr_t         host_addr,
	input  restart_pkg::cu_t           host_cu,
	input  restart_pkg::cmd_kind_t     host_kind,
	input  logic                       rsp_valid,
	input  restart_pkg::tag_t          rsp_tag,
	input  restart_pkg::rsp_code_t     rsp_code,
	input  restart_pkg::credit_t       credits_used,
	output logic                       host_ready,
	output logic                       restart_pending,
	cmd_line_if.source                 cmd
);
	import restart_pkg::*;

	logic rsp_fault;
	logic rsp_flush;
	logic early_hit;
	logic rsp_q_valid;
	logic rsp_q_fault;
	logic rsp_q_flush;
	tag_t rsp_q_tag;
	logic rsp_s2_valid;
	logic rsp_s2_fault;
	logic rsp_s2_flush;
	tag_t rsp_s2_tag;

	cmd_entry_t tbl_wr_data;
	cmd_entry_t tbl_rd_data;
	replay_entry_t fifo_in;
	replay_entry_t fifo_out;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_full;

	logic s2_is_restart;
	logic trigger_s2;
	logic flush_s2;
	logic restart_sent;
	credit_t restarts_out;
	credit_t credits_ahead;
	logic quiet;
	logic host_fire;
	logic sel_restart;
	logic sel_replay;

	restart_state_e state;
	restart_state_e state_nxt;

	function automatic logic fault_enabled(input rsp_code_t code, input restart_mask_t mask);
		case (code)
			RSP_PAGED: return mask[MASK_PAGED];
			RSP_AERROR: return mask[MASK_AERROR];
			RSP_DERROR: return mask[MASK_DERROR];
			default: return 1'b0;
		endcase
	endfunction

	//////////////////////////////
	// Response pipeline
	//////////////////////////////

	// Mask sampled once, on arrival
	assign rsp_fault = rsp_valid && fault_enabled(rsp_code, restart_mask);
	assign rsp_flush = rsp_valid && (rsp_code == RSP_FLUSHED);
	assign early_hit = enable && (rsp_fault || rsp_flush);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rsp_q_valid <= 1'b0;
			rsp_q_fault <= 1'b0;
			rsp_q_flush <= 1'b0;
			rsp_s2_valid <= 1'b0;
			rsp_s2_fault <= 1'b0;
			rsp_s2_flush <= 1'b0;
		end else if (~enable) begin
			rsp_q_valid <= 1'b0;
			rsp_q_fault <= 1'b0;
			rsp_q_flush <= 1'b0;
			rsp_s2_valid <= 1'b0;
			rsp_s2_fault <= 1'b0;
			rsp_s2_flush <= 1'b0;
		end else begin
			rsp_q_valid <= rsp_valid;
			rsp_q_fault <= rsp_fault;
			rsp_q_flush <= rsp_flush;
			rsp_s2_valid <= rsp_q_valid;
			rsp_s2_fault <= rsp_q_fault;
			rsp_s2_flush <= rsp_q_flush;
		end
	end

	always_ff @(posedge clock) begin
		rsp_q_tag <= rsp_tag;
		rsp_s2_tag <= rsp_q_tag;
	end

	// Every outbound command lands in the table
	assign tbl_wr_data = '{addr: cmd.addr, cu: cmd.cu, kind: cmd.kind};

	tag_ram #(
		.DEPTH(`RST_TAG_COUNT),
		.WIDTH($bits(cmd_entry_t))
	) u_tag_ram (
		.clock  (clock),
		.we     (cmd.valid),
		.wr_addr(cmd.tag),
		.wr_data(tbl_wr_data),
		.rd_addr(rsp_q_tag),
		.rd_data(tbl_rd_data)
	);

	assign s2_is_restart = rsp_s2_valid && (tbl_rd_data.kind == KIND_RESTART);
	assign trigger_s2 = rsp_s2_fault && (tbl_rd_data.kind != KIND_RESTART);
	assign flush_s2 = rsp_s2_flush && (tbl_rd_data.kind != KIND_RESTART);

	assign fifo_push = flush_s2;
	assign fifo_in = '{tag: rsp_s2_tag, entry: tbl_rd_data};

	replay_fifo #(
		.DEPTH(`RST_TAG_COUNT),
		.WIDTH($bits(replay_entry_t))
	) u_replay_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (fifo_push),
		.push_data(fifo_in),
		.pop      (fifo_pop),
		.pop_data (fifo_out),
		.empty    (fifo_empty),
		.full     (fifo_full)
	);

	//////////////////////////////
	// Outstanding restarts
	//////////////////////////////

	assign restart_sent = cmd.valid && (cmd.kind == KIND_RESTART);

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			restarts_out <= '0;
		end else if (~enable) begin
			restarts_out <= '0;
		end else begin
			case ({restart_sent, s2_is_restart})
				2'b10: restarts_out <= restarts_out + 1'b1;
				2'b01: restarts_out <= restarts_out - 1'b1;
				default: restarts_out <= restarts_out;
			endcase
		end
	end

	// Command on the port now is not yet counted by the tracker
	assign credits_ahead = credits_used + credit_t'(cmd.valid);

	// Nothing in flight anywhere on the link or in the pipeline
	assign quiet = (credits_used == '0) && !cmd.valid && !rsp_q_valid && !rsp_s2_valid
		&& (restarts_out == '0);

	//////////////////////////////
	// Restart FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state <= IDLE;
		end else if (~enable) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (early_hit)
					state_nxt = RESP_WAIT;
			end
			RESP_WAIT: begin
				if (trigger_s2)
					state_nxt = RESTART;
				else if (quiet)
					state_nxt = fifo_empty ? DONE : REPLAY;
			end
			RESTART: begin
				if (!trigger_s2)
					state_nxt = RESP_WAIT;
			end
			REPLAY: begin
				// A fresh trigger pauses the pops
				if (trigger_s2)
					state_nxt = RESTART;
				else if (fifo_empty)
					state_nxt = RESP_WAIT;
			end
			DONE: begin
				state_nxt = early_hit ? RESP_WAIT : IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	assign restart_pending = enable && (state inside {RESTART, RESP_WAIT, REPLAY});
	assign host_ready = enable && (state inside {IDLE, DONE}) && !fifo_full
		&& (credits_ahead < credit_t'(`RST_CREDITS));

	//////////////////////////////
	// Outbound command select
	//////////////////////////////

	assign host_fire = host_valid && host_ready;
	assign sel_restart = trigger_s2;
	assign sel_replay = (state == REPLAY) && !fifo_empty && !trigger_s2;
	assign fifo_pop = sel_replay;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			cmd.valid <= 1'b0;
			cmd.strict <= 1'b0;
		end else if (~enable) begin
			cmd.valid <= 1'b0;
			cmd.strict <= 1'b0;
		end else begin
			cmd.valid <= sel_restart || sel_replay || host_fire;
			cmd.strict <= sel_restart || sel_replay;
		end
	end

	// Restart first, then replay, then host
	always_ff @(posedge clock) begin
		if (sel_restart) begin
			cmd.tag <= rsp_s2_tag;
			cmd.addr <= tbl_rd_data.addr;
			cmd.cu <= `RST_RESTART_CU;
			cmd.kind <= KIND_RESTART;
		end else if (sel_replay) begin
			cmd.tag <= fifo_out.tag;
			cmd.addr <= fifo_out.entry.addr;
			cmd.cu <= fifo_out.entry.cu;
			cmd.kind <= fifo_out.entry.kind;
		end else if (host_fire) begin
			cmd.tag <= host_tag;
			cmd.addr <= host_addr;
			cmd.cu <= host_cu;
			cmd.kind <= host_kind;
		end
	end

endmodule

/* verilog/restart_top.sv */
//////////////////////////////
// Restart path top level
// Host, response and command lines are plain strobes
// Flow is bounded by credits and host_ready only
//////////////////////////////

`timescale 1ns/1ns

module restart_top (
	input  logic                   clock,
	input  logic                   rstn,
	// Configuration
	input  logic                   cfg_we,
	input  logic                   cfg_addr,
	input  logic [7:0]             cfg_wdata,
	// Host issue
	input  logic                   host_valid,
	input  restart_pkg::tag_t      host_tag,
	input  restart_pkg::addr_t     host_addr,
	input  restart_pkg::cu_t       host_cu,
	input  restart_pkg::cmd_kind_t host_kind,
	// Responses
	input  logic                   rsp_valid,
	input  restart_pkg::tag_t      rsp_tag,
	input  restart_pkg::rsp_code_t rsp_code,
	// Status
	output logic                   host_ready,
	output logic                   restart_pending,
	// Outbound commands
	output logic                   out_valid,
	output restart_pkg::tag_t      out_tag,
	output restart_pkg::addr_t     out_addr,
	output restart_pkg::cu_t       out_cu,
	output restart_pkg::cmd_kind_t out_kind,
	output logic                   out_strict
);
	import restart_pkg::*;

	logic enable;
	restart_mask_t restart_mask;
	credit_t credits_used;

	cmd_line_if cmd_line ();

	restart_config u_config (
		.clock       (clock),
		.rstn        (rstn),
		.cfg_we      (cfg_we),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.enable      (enable),
		.restart_mask(restart_mask)
	);

	restart_control u_control (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.restart_mask   (restart_mask),
		.host_valid     (host_valid),
		.host_tag       (host_tag),
		.host_addr      (host_addr),
		.host_cu        (host_cu),
		.host_kind      (host_kind),
		.rsp_valid      (rsp_valid),
		.rsp_tag        (rsp_tag),
		.rsp_code       (rsp_code),
		.credits_used   (credits_used),
		.host_ready     (host_ready),
		.restart_pending(restart_pending),
		.cmd            (cmd_line.source)
	);

	credit_tracker u_credit (
		.clock       (clock),
		.rstn        (rstn),
		.cmd         (cmd_line.sink),
		.rsp_valid   (rsp_valid),
		.credits_used(credits_used)
	);

	// Command line out to the link
	assign out_valid = cmd_line.valid;
	assign out_tag = cmd_line.tag;
	assign out_addr = cmd_line.addr;
	assign out_cu = cmd_line.cu;
	assign out_kind = cmd_line.kind;
	assign out_strict = cmd_line.strict;

endmodule

/* sim/restart_tb.sv */
//////////////////////////////
// Random host and responder around the restart path
// Responses to strict commands are always done
// Config changes only while the link is idle
//////////////////////////////

`timescale 1ns/1ns
`include "restart_defines.svh"

module restart_tb;
	import restart_pkg::*;

	localparam int P_PASS = 300;
	localparam int P_RESTART = 600;
	localparam int P_AFTER = 200;
	localparam int MAX_DLY = 12;
	localparam int WATCHDOG_NS = (P_PASS + P_RESTART + P_AFTER + 200) * (MAX_DLY + 8) * 8;

	typedef struct packed {
		tag_t tag;
		addr_t addr;
		cu_t cu;
		cmd_kind_t kind;
		logic [31:0] due;
	} exp_t;

	logic clock = 1'b0;
	logic rstn;
	logic cfg_we;
	logic cfg_addr;
	logic [7:0] cfg_wdata;
	logic host_valid;
	tag_t host_tag;
	addr_t host_addr;
	cu_t host_cu;
	cmd_kind_t host_kind;
	logic rsp_valid;
	tag_t rsp_tag;
	rsp_code_t rsp_code;
	logic host_ready;
	logic restart_pending;
	logic out_valid;
	tag_t out_tag;
	addr_t out_addr;
	cu_t out_cu;
	cmd_kind_t out_kind;
	logic out_strict;

	// Model state per tag
	logic busy [`RST_TAG_COUNT];
	logic live [`RST_TAG_COUNT];
	logic ent_strict [`RST_TAG_COUNT];
	int rsp_due [`RST_TAG_COUNT];
	int free_at [`RST_TAG_COUNT];
	cmd_entry_t ent [`RST_TAG_COUNT];

	exp_t host_q [$];
	exp_t restart_q [$];
	exp_t replay_q [$];

	integer seed;
	int cyc = 0;
	int in_use = 0;
	int last_rsp = 0;
	int max_dly;
	int n_restart = 0;
	int n_replay = 0;
	logic host_on = 1'b0;
	logic rsp_on = 1'b0;
	logic flush_on = 1'b0;
	logic ready_exact = 1'b0;
	logic prev_replay = 1'b0;
	logic pend_chk = 1'b0;
	restart_mask_t mask_m = '0;

	restart_top u_dut (
		.clock(clock), .rstn(rstn),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.host_valid(host_valid), .host_tag(host_tag), .host_addr(host_addr),
		.host_cu(host_cu), .host_kind(host_kind),
		.rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_code(rsp_code),
		.host_ready(host_ready), .restart_pending(restart_pending),
		.out_valid(out_valid), .out_tag(out_tag), .out_addr(out_addr),
		.out_cu(out_cu), .out_kind(out_kind), .out_strict(out_strict)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cyc <= cyc + 1;
	end

	task automatic report_fail(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_cmd(input tag_t tag, input addr_t addr, input cu_t cu,
			input cmd_kind_t kind, input logic strict);
		if (out_tag !== tag || out_addr !== addr || out_cu !== cu
				|| out_kind !== kind || out_strict !== strict) begin
			report_fail($sformatf("command %0h %h %h %0d %b, expected %0h %h %h %0d %b",
				out_tag, out_addr, out_cu, out_kind, out_strict,
				tag, addr, cu, kind, strict));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			report_fail($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	// Match what the DUT put on the port at the last edge
	task automatic observe();
		exp_t e;
		logic strict_e;
		e = '0;
		strict_e = 1'b0;
		if (out_valid === 1'b1) begin
			if (!out_strict) begin
				if (host_q.size() == 0) begin
					report_fail("unexpected host command on the port");
				end else begin
					e = host_q.pop_front();
					check_cmd(e.tag, e.addr, e.cu, e.kind, 1'b0);
					if (e.due != cyc)
						report_fail("host command out of its slot");
				end
			end else if (out_kind == KIND_RESTART) begin
				if (restart_q.size() == 0) begin
					report_fail("unexpected restart command");
				end else begin
					e = restart_q.pop_front();
					strict_e = 1'b1;
					check_cmd(e.tag, e.addr, e.cu, e.kind, 1'b1);
					if (e.due != cyc)
						report_fail("restart command out of its slot");
					in_use++;
					n_restart++;
				end
			end else begin
				if (replay_q.size() == 0) begin
					report_fail("unexpected replay command");
				end else if (!prev_replay && (in_use != 0 || restart_q.size() != 0)) begin
					report_fail("replay started with commands still outstanding");
				end else begin
					e = replay_q.pop_front();
					strict_e = 1'b1;
					check_cmd(e.tag, e.addr, e.cu, e.kind, 1'b1);
					in_use++;
					n_replay++;
				end
			end
			live[e.tag] = 1'b1;
			rsp_due[e.tag] = cyc + 1 + ($unsigned($random(seed)) % max_dly);
			ent[e.tag] = '{addr: e.addr, cu: e.cu, kind: e.kind};
			ent_strict[e.tag] = strict_e;
		end
		prev_replay = (out_valid === 1'b1) && out_strict && (out_kind != KIND_RESTART);
		if (host_q.size() != 0 && host_q[0].due <= cyc)
			report_fail("accepted host command never went out");
		if (restart_q.size() != 0 && restart_q[0].due <= cyc)
			report_fail("restart command missing three cycles after the fault");
	endtask

	task automatic respond();
		int sel;
		int r;
		logic found;
		logic trig;
		rsp_code_t code;
		rsp_valid = 1'b0;
		found = 1'b0;
		sel = 0;
		for (int t = 0; t < `RST_TAG_COUNT; t++) begin
			if (!found && live[t] && rsp_due[t] <= cyc) begin
				found = 1'b1;
				sel = t;
			end
		end
		if (rsp_on && found) begin
			r = $unsigned($random(seed)) % 16;
			if (ent_strict[sel] || r < 8)
				code = RSP_DONE;
			else if (r < 10)
				code = RSP_PAGED;
			else if (r < 12)
				code = RSP_AERROR;
			else if (r < 14)
				code = RSP_DERROR;
			else
				code = flush_on ? RSP_FLUSHED : RSP_DONE;
			rsp_valid = 1'b1;
			rsp_tag = tag_t'(sel);
			rsp_code = code;
			live[sel] = 1'b0;
			in_use--;
			last_rsp = cyc;
			trig = (ent[sel].kind != KIND_RESTART)
				&& ((code == RSP_PAGED && mask_m[MASK_PAGED])
				|| (code == RSP_AERROR && mask_m[MASK_AERROR])
				|| (code == RSP_DERROR && mask_m[MASK_DERROR]));
			if (trig) begin
				restart_q.push_back('{tag: tag_t'(sel), addr: ent[sel].addr,
					cu: `RST_RESTART_CU, kind: KIND_RESTART, due: cyc + 3});
				pend_chk = 1'b1;
			end else if (code == RSP_FLUSHED && ent[sel].kind != KIND_RESTART) begin
				replay_q.push_back('{tag: tag_t'(sel), addr: ent[sel].addr,
					cu: ent[sel].cu, kind: ent[sel].kind, due: 0});
				pend_chk = 1'b1;
			end else begin
				// Tag rests a few cycles so the table read sees the old entry
				busy[sel] = 1'b0;
				free_at[sel] = cyc + 4;
			end
		end
	endtask

	task automatic issue();
		int sel;
		int start;
		int t;
		logic found;
		host_valid = 1'b0;
		found = 1'b0;
		sel = 0;
		start = $unsigned($random(seed)) % `RST_TAG_COUNT;
		for (int k = 0; k < `RST_TAG_COUNT; k++) begin
			t = (start + k) % `RST_TAG_COUNT;
			if (!found && !busy[t] && free_at[t] <= cyc) begin
				found = 1'b1;
				sel = t;
			end
		end
		if (host_on && found && ($unsigned($random(seed)) % 4) != 0) begin
			host_valid = 1'b1;
			host_tag = tag_t'(sel);
			host_addr = $random(seed);
			host_cu = $random(seed);
			host_kind = $random(seed) & 1 ? KIND_WRITE : KIND_READ;
			if (host_ready === 1'b1) begin
				busy[sel] = 1'b1;
				in_use++;
				host_q.push_back('{tag: host_tag, addr: host_addr, cu: host_cu,
					kind: host_kind, due: cyc + 1});
			end
		end
	endtask

	// One clock of checks and stimulus, from falling edge to falling edge
	task automatic step();
		if (pend_chk)
			check_level("restart_pending", 1'b1, restart_pending);
		pend_chk = 1'b0;
		observe();
		if (ready_exact)
			check_level("host_ready", in_use < `RST_CREDITS, host_ready);
		else if (host_ready === 1'b1 && in_use >= `RST_CREDITS)
			report_fail("host_ready high with every credit in use");
		respond();
		issue();
		@(negedge clock);
	endtask

	task automatic write_cfg(input logic addr, input logic [7:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		step();
		cfg_we = 1'b0;
	endtask

	task automatic drain();
		host_on = 1'b0;
		while (in_use != 0 || host_q.size() != 0 || restart_q.size() != 0
				|| replay_q.size() != 0 || restart_pending === 1'b1 || cyc < last_rsp + 4)
			step();
		// Ready again as soon as the episode is over
		check_level("host_ready", 1'b1, host_ready);
		step();
		step();
		check_level("restart_pending", 1'b0, restart_pending);
		check_level("host_ready", 1'b1, host_ready);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		seed = 32'h27e47464;
		rstn = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = '0;
		host_valid = 1'b0;
		host_tag = '0;
		host_addr = '0;
		host_cu = '0;
		host_kind = KIND_READ;
		rsp_valid = 1'b0;
		rsp_tag = '0;
		rsp_code = RSP_DONE;
		max_dly = MAX_DLY;
		for (int i = 0; i < `RST_TAG_COUNT; i++) begin
			busy[i] = 1'b0;
			live[i] = 1'b0;
			ent_strict[i] = 1'b0;
			rsp_due[i] = 0;
			free_at[i] = 0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		check_level("host_ready", 1'b0, host_ready);
		check_level("restart_pending", 1'b0, restart_pending);
		check_level("out_valid", 1'b0, out_valid);
		write_cfg(1'b1, 8'h00);
		write_cfg(1'b0, 8'h01);

		// Pass-through, faults all masked
		host_on = 1'b1;
		rsp_on = 1'b1;
		ready_exact = 1'b1;
		repeat (P_PASS) step();
		ready_exact = 1'b0;
		drain();

		// Paged and data errors restart, address errors stay masked
		write_cfg(1'b1, 8'h05);
		mask_m = 3'b101;
		flush_on = 1'b1;
		max_dly = 6;
		host_on = 1'b1;
		repeat (P_RESTART) step();
		drain();

		// Disabled port stays silent
		write_cfg(1'b0, 8'h00);
		host_on = 1'b1;
		repeat (10) begin
			check_level("host_ready", 1'b0, host_ready);
			check_level("out_valid", 1'b0, out_valid);
			step();
		end
		host_on = 1'b0;
		write_cfg(1'b1, 8'h00);
		mask_m = '0;
		write_cfg(1'b0, 8'h01);

		// Back to plain pass-through
		flush_on = 1'b0;
		max_dly = MAX_DLY;
		host_on = 1'b1;
		ready_exact = 1'b1;
		repeat (P_AFTER) step();
		ready_exact = 1'b0;
		drain();

		if (n_restart == 0 || n_replay == 0) begin
			$display("No restart or replay traffic was produced by the random stimulus");
			$display("STATUS: FAIL");
			$fatal(1, "no coverage");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* filelist.f */
+incdir+verilog
verilog/restart_pkg.sv
verilog/cmd_line_if.sv
verilog/tag_ram.sv
verilog/replay_fifo.sv
verilog/credit_tracker.sv
verilog/restart_config.sv
verilog/restart_control.sv
verilog/restart_top.sv
sim/restart_tb.sv
